/* include/mreg_params.svh */
`ifndef MREG_PARAMS_SVH
`define MREG_PARAMS_SVH

// --------------------------------------------------
// bus field widths
// --------------------------------------------------

// master side is fixed to a 32-bit address
`define MREG_ADDR_W 32
`define MREG_OPCODE_W 8
`define MREG_BE_W 4

// longest message is 6 + 6 + 8 = 20 flits
`define MREG_FLIT_W 5

// saturating count of results lost while a report is pending
`define MREG_DROP_W 8

`define MREG_NUM_RULES 7

// --------------------------------------------------
// flit counts per message section
// --------------------------------------------------

`define MREG_HDR_FLITS 6
`define MREG_ADDR16_FLITS 2
`define MREG_ADDR48_FLITS 6
`define MREG_DATA32_FLITS 4
`define MREG_DATA64_FLITS 8

`endif

/* rtl/mreg_msg_pkg.sv */
`include "mreg_params.svh"

package mreg_msg_pkg;

   // --------------------------------------------------
   // register access message fields
   // --------------------------------------------------

   typedef logic [`MREG_OPCODE_W-1:0] opcode_t;

   typedef logic [`MREG_ADDR_W-1:0] addr_t;

   // used for both fbe and sbe
   typedef logic [`MREG_BE_W-1:0] be_t;

   // message length in flits, header included
   typedef logic [`MREG_FLIT_W-1:0] flit_cnt_t;

   // --------------------------------------------------
   // opcodes of the register access group
   // --------------------------------------------------

   // memory space
   localparam opcode_t OP_MRD = 8'h00;
   localparam opcode_t OP_MWR = 8'h01;

   // io space
   localparam opcode_t OP_IORD = 8'h02;
   localparam opcode_t OP_IOWR = 8'h03;

   // configuration space
   localparam opcode_t OP_CFGRD = 8'h04;
   localparam opcode_t OP_CFGWR = 8'h05;

   // reads are even, writes odd
   localparam int OP_WRITE_BIT = 0;

endpackage

/* rtl/mreg_check_pkg.sv */
`include "mreg_params.svh"

package mreg_check_pkg;

   // --------------------------------------------------
   // access rules, one violation bit each
   // --------------------------------------------------

   localparam int RULE_OPCODE = 0;
   localparam int RULE_POSTED_READ = 1;
   localparam int RULE_POSTED_CFGIO_WR = 2;
   localparam int RULE_NPWRITE = 3;
   localparam int RULE_CFGIO_ADDRLEN = 4;
   localparam int RULE_DW_ALIGN = 5;
   localparam int RULE_QW_ALIGN = 6;

   // bit set means the rule was broken
   typedef logic [`MREG_NUM_RULES-1:0] rule_vec_t;

   // --------------------------------------------------
   // report side
   // --------------------------------------------------

   // four-phase report sequencing
   typedef enum logic [1:0] {
      IDLE,
      REQ,
      RELEASE
   } ctrl_state_e;

   typedef logic [`MREG_DROP_W-1:0] drop_cnt_t;

   // counter holds here once reached
   localparam drop_cnt_t DROP_MAX = '1;

endpackage

/* rtl/mreg_rec_if.sv */
`timescale 1ns/10ps

// one captured transfer, strobed by valid for a single cycle
interface mreg_rec_if;
   import mreg_msg_pkg::*;

   logic valid;
   opcode_t opcode;
   logic posted;
   logic npwrite;
   logic addrlen;
   be_t fbe;
   be_t sbe;
   addr_t addr;
   flit_cnt_t flits;

   modport src (
      output valid, opcode, posted, npwrite, addrlen, fbe, sbe, addr, flits
   );

   modport dst (
      input valid, opcode, posted, npwrite, addrlen, fbe, sbe, addr, flits
   );

endinterface

/* rtl/mreg_res_if.sv */
`timescale 1ns/10ps

// one evaluated message, no back-pressure toward the evaluator
interface mreg_res_if;
   import mreg_msg_pkg::*;
   import mreg_check_pkg::*;

   logic valid;
   rule_vec_t rules;
   flit_cnt_t flits;
   logic posted;

   modport src (output valid, rules, flits, posted);

   modport dst (input valid, rules, flits, posted);

endinterface

/* rtl/mreg_capture.sv */
`timescale 1ns/10ps
`include "mreg_params.svh"

module mreg_capture (
   input logic clk,
   input logic reset,
   input logic mreg_irdy,
   input logic mreg_trdy,
   input logic mreg_pmsgip,
   input logic mreg_nmsgip,
   input logic mreg_npwrite,
   input logic mreg_addrlen,
   input mreg_msg_pkg::opcode_t mreg_opcode,
   input mreg_msg_pkg::be_t mreg_fbe,
   input mreg_msg_pkg::be_t mreg_sbe,
   input mreg_msg_pkg::addr_t mreg_addr,
   mreg_rec_if.src rec
);
   import mreg_msg_pkg::*;

   logic accept;
   flit_cnt_t addr_flits;
   flit_cnt_t data_flits;
   flit_cnt_t flits_next;

   // a transfer counts only while one of the message flags is up
   assign accept = mreg_irdy && mreg_trdy && (mreg_pmsgip || mreg_nmsgip);

   // --------------------------------------------------
   // message length
   // --------------------------------------------------

   // addrlen 1 selects the long address form
   assign addr_flits = mreg_addrlen ? flit_cnt_t'(`MREG_ADDR48_FLITS)
                                    : flit_cnt_t'(`MREG_ADDR16_FLITS);

   // reads carry no data, writes one or two dwords by sbe
   always_comb begin
      if (!mreg_opcode[OP_WRITE_BIT])
         data_flits = '0;
      else if (mreg_sbe == '0)
         data_flits = flit_cnt_t'(`MREG_DATA32_FLITS);
      else
         data_flits = flit_cnt_t'(`MREG_DATA64_FLITS);
   end

   assign flits_next = flit_cnt_t'(`MREG_HDR_FLITS) + addr_flits + data_flits;

   // --------------------------------------------------
   // record register
   // --------------------------------------------------

   always_ff @(posedge clk or negedge reset) begin
      if (!reset)
         rec.valid <= 1'b0;
      else
         rec.valid <= accept;
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rec.opcode <= mreg_opcode;
         // both flags together are treated as non-posted
         rec.posted <= mreg_pmsgip && !mreg_nmsgip;
         rec.npwrite <= mreg_npwrite;
         rec.addrlen <= mreg_addrlen;
         rec.fbe <= mreg_fbe;
         rec.sbe <= mreg_sbe;
         rec.addr <= mreg_addr;
         rec.flits <= flits_next;
      end
   end

   // every message is a whole number of dwords
   flits_dw_multiple: assert property (
      @(posedge clk) disable iff (!reset)
      rec.valid |-> (rec.flits[1:0] == 2'b00)
   ) else $error("mreg_capture: flit count %0d is not a dword multiple", rec.flits);

endmodule

/* rtl/mreg_rule_eval.sv */
`timescale 1ns/10ps

module mreg_rule_eval (
   input logic clk,
   input logic reset,
   mreg_rec_if.dst rec,
   mreg_res_if.src res
);
   import mreg_msg_pkg::*;
   import mreg_check_pkg::*;

   logic is_mem;
   logic is_io;
   logic is_cfg;
   logic is_valid;
   logic is_read;
   logic is_write;
   rule_vec_t rules_next;

   // --------------------------------------------------
   // opcode groups
   // --------------------------------------------------

   assign is_mem = (rec.opcode == OP_MRD) || (rec.opcode == OP_MWR);
   assign is_io = (rec.opcode == OP_IORD) || (rec.opcode == OP_IOWR);
   assign is_cfg = (rec.opcode == OP_CFGRD) || (rec.opcode == OP_CFGWR);
   assign is_valid = is_mem || is_io || is_cfg;

   // read and write only within the six known opcodes
   assign is_write = is_valid && rec.opcode[OP_WRITE_BIT];
   assign is_read = is_valid && !rec.opcode[OP_WRITE_BIT];

   // --------------------------------------------------
   // access rules
   // --------------------------------------------------

   always_comb begin
      rules_next = '0;
      rules_next[RULE_OPCODE] = !is_valid;
      // reads always expect a completion
      rules_next[RULE_POSTED_READ] = rec.posted && is_read;
      rules_next[RULE_POSTED_CFGIO_WR] = rec.posted && is_write && (is_io || is_cfg);
      // npwrite has to agree with the message class
      rules_next[RULE_NPWRITE] = is_write && (rec.npwrite != !rec.posted);
      // io and cfg space only use the short address
      rules_next[RULE_CFGIO_ADDRLEN] = (is_io || is_cfg) && rec.addrlen;
      rules_next[RULE_DW_ALIGN] = ((is_mem || is_io) && (rec.addr[1:0] != 2'b00))
                                  || (is_cfg && rec.addr[1]);
      // a second dword needs a qword aligned start
      rules_next[RULE_QW_ALIGN] = is_valid && (rec.sbe != '0) && rec.addr[2];
   end

   // --------------------------------------------------
   // result register
   // --------------------------------------------------

   always_ff @(posedge clk or negedge reset) begin
      if (!reset)
         res.valid <= 1'b0;
      else
         res.valid <= rec.valid;
   end

   always_ff @(posedge clk) begin
      if (rec.valid) begin
         res.rules <= rules_next;
         res.flits <= rec.flits;
         res.posted <= rec.posted;
      end
   end

   // no record is lost or duplicated on the way to the control
   result_follows_record: assert property (
      @(posedge clk) disable iff (!reset)
      res.valid == $past(rec.valid)
   ) else $error("mreg_rule_eval: result strobe out of step with record strobe");

endmodule

/* rtl/mreg_check_ctrl.sv */
`timescale 1ns/10ps

module mreg_check_ctrl (
   input logic clk,
   input logic reset,
   mreg_res_if.dst res,
   input logic rpt_ack,
   output logic rpt_req,
   output mreg_check_pkg::rule_vec_t rpt_rules,
   output mreg_msg_pkg::flit_cnt_t rpt_flits,
   output logic rpt_posted,
   output mreg_check_pkg::drop_cnt_t drop_count
);
   import mreg_check_pkg::*;

   ctrl_state_e state;
   logic take;

   // only an idle control can accept a new result
   assign take = res.valid && (state == IDLE);

   // --------------------------------------------------
   // four-phase report FSM
   // --------------------------------------------------

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= IDLE;
         rpt_req <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (res.valid) begin
                  state <= REQ;
                  rpt_req <= 1'b1;
               end
            end
            REQ: begin
               // hold the request until the environment answers
               if (rpt_ack) begin
                  state <= RELEASE;
                  rpt_req <= 1'b0;
               end
            end
            RELEASE: begin
               if (!rpt_ack)
                  state <= IDLE;
            end
            default: begin
               state <= IDLE;
               rpt_req <= 1'b0;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         rpt_rules <= res.rules;
         rpt_flits <= res.flits;
         rpt_posted <= res.posted;
      end
   end

   // results seen while busy are lost, count them
   always_ff @(posedge clk or negedge reset) begin
      if (!reset)
         drop_count <= '0;
      else if (res.valid && (state != IDLE) && (drop_count != DROP_MAX))
         drop_count <= drop_count + 1'b1;
   end

   report_stable: assert property (
      @(posedge clk) disable iff (!reset)
      rpt_req && $past(rpt_req) |-> $stable({rpt_rules, rpt_flits, rpt_posted})
   ) else $error("mreg_check_ctrl: report fields changed during request");

   req_rise_from_idle: assert property (
      @(posedge clk) disable iff (!reset)
      $rose(rpt_req) |-> ($past(state) == IDLE)
   ) else $error("mreg_check_ctrl: request raised outside idle");

endmodule

/* rtl/mreg_checker_top.sv */
`timescale 1ns/10ps

module mreg_checker_top (
   input logic clk,
   input logic reset,
   input logic mreg_irdy,
   input logic mreg_trdy,
   input logic mreg_pmsgip,
   input logic mreg_nmsgip,
   input logic mreg_npwrite,
   input logic mreg_addrlen,
   input mreg_msg_pkg::opcode_t mreg_opcode,
   input mreg_msg_pkg::be_t mreg_fbe,
   input mreg_msg_pkg::be_t mreg_sbe,
   input mreg_msg_pkg::addr_t mreg_addr,
   input logic rpt_ack,
   output logic rpt_req,
   output mreg_check_pkg::rule_vec_t rpt_rules,
   output mreg_msg_pkg::flit_cnt_t rpt_flits,
   output logic rpt_posted,
   output mreg_check_pkg::drop_cnt_t drop_count
);

   // --------------------------------------------------
   // stage links
   // --------------------------------------------------

   mreg_rec_if u_rec_if ();
   mreg_res_if u_res_if ();

   // stage 1, sample the bus
   mreg_capture u_mreg_capture (
      .clk (clk),
      .reset (reset),
      .mreg_irdy (mreg_irdy),
      .mreg_trdy (mreg_trdy),
      .mreg_pmsgip (mreg_pmsgip),
      .mreg_nmsgip (mreg_nmsgip),
      .mreg_npwrite (mreg_npwrite),
      .mreg_addrlen (mreg_addrlen),
      .mreg_opcode (mreg_opcode),
      .mreg_fbe (mreg_fbe),
      .mreg_sbe (mreg_sbe),
      .mreg_addr (mreg_addr),
      .rec (u_rec_if.src)
   );

   // stage 2, rule checks
   mreg_rule_eval u_mreg_rule_eval (
      .clk (clk),
      .reset (reset),
      .rec (u_rec_if.dst),
      .res (u_res_if.src)
   );

   // stage 3, report handshake
   mreg_check_ctrl u_mreg_check_ctrl (
      .clk (clk),
      .reset (reset),
      .res (u_res_if.dst),
      .rpt_ack (rpt_ack),
      .rpt_req (rpt_req),
      .rpt_rules (rpt_rules),
      .rpt_flits (rpt_flits),
      .rpt_posted (rpt_posted),
      .drop_count (drop_count)
   );

endmodule

/* testbench/tb_mreg_checker.sv */
`timescale 1ns/10ps
`include "mreg_params.svh"

module tb_mreg_checker;
   import mreg_msg_pkg::*;
   import mreg_check_pkg::*;

   typedef struct packed {
      logic posted;
      flit_cnt_t flits;
      rule_vec_t rules;
   } report_t;

   localparam int N_LEGAL = 24;
   localparam int N_CLASS = 24;
   localparam int N_OPCODE = 24;
   localparam int N_ALIGN = 32;
   localparam int K_DROP_A = 5;
   localparam int K_DROP_B = 3;
   localparam int N_TOTAL = N_LEGAL + N_CLASS + N_OPCODE + N_ALIGN + K_DROP_A + K_DROP_B;
   localparam int TIMEOUT_CYCLES = 40 * N_TOTAL + 200;

   logic clk;
   logic reset;
   logic mreg_irdy;
   logic mreg_trdy;
   logic mreg_pmsgip;
   logic mreg_nmsgip;
   logic mreg_npwrite;
   logic mreg_addrlen;
   opcode_t mreg_opcode;
   be_t mreg_fbe;
   be_t mreg_sbe;
   addr_t mreg_addr;
   logic rpt_ack;
   logic rpt_req;
   rule_vec_t rpt_rules;
   flit_cnt_t rpt_flits;
   logic rpt_posted;
   drop_cnt_t drop_count;

   report_t exp_q[$];
   logic [31:0] stim_state = 32'heee0_be62;
   logic [31:0] ack_state = 32'heee0_be62 ^ 32'h9e37_79b9;
   logic ack_hold = 1'b0;
   string cur_test = "reset";
   int value_errors = 0;
   int protocol_errors = 0;
   int reports_seen = 0;
   int cycle_count = 0;
   logic prev_req = 1'b0;
   logic prev_ack = 1'b0;

   mreg_checker_top u_mreg_checker_top (
      .clk (clk),
      .reset (reset),
      .mreg_irdy (mreg_irdy),
      .mreg_trdy (mreg_trdy),
      .mreg_pmsgip (mreg_pmsgip),
      .mreg_nmsgip (mreg_nmsgip),
      .mreg_npwrite (mreg_npwrite),
      .mreg_addrlen (mreg_addrlen),
      .mreg_opcode (mreg_opcode),
      .mreg_fbe (mreg_fbe),
      .mreg_sbe (mreg_sbe),
      .mreg_addr (mreg_addr),
      .rpt_ack (rpt_ack),
      .rpt_req (rpt_req),
      .rpt_rules (rpt_rules),
      .rpt_flits (rpt_flits),
      .rpt_posted (rpt_posted),
      .drop_count (drop_count)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // --------------------------------------------------
   // random numbers and reference model
   // --------------------------------------------------

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] stim_rand();
      stim_state = xorshift32(stim_state);
      return stim_state;
   endfunction

   function automatic logic [31:0] ack_rand();
      ack_state = xorshift32(ack_state);
      return ack_state;
   endfunction

   // header, then 2 or 6 address flits, then 0, 4 or 8 data flits
   function automatic flit_cnt_t model_flits(input opcode_t op, input logic al, input be_t sbe);
      int n;
      n = `MREG_HDR_FLITS;
      n += al ? `MREG_ADDR48_FLITS : `MREG_ADDR16_FLITS;
      if (op[0])
         n += (sbe == 4'h0) ? `MREG_DATA32_FLITS : `MREG_DATA64_FLITS;
      return flit_cnt_t'(n);
   endfunction

   function automatic rule_vec_t model_rules(input opcode_t op, input logic posted,
                                             input logic npw, input logic al,
                                             input be_t sbe, input addr_t addr);
      rule_vec_t v;
      logic known;
      logic wr;
      logic mem_io;
      logic cfg;
      v = '0;
      known = (op <= 8'h05);
      wr = known && op[0];
      mem_io = (op <= 8'h03);
      cfg = (op == OP_CFGRD) || (op == OP_CFGWR);
      v[RULE_OPCODE] = !known;
      v[RULE_POSTED_READ] = known && !wr && posted;
      v[RULE_POSTED_CFGIO_WR] = wr && posted && (op != OP_MWR);
      // npwrite must be the inverse of posted
      v[RULE_NPWRITE] = wr && (npw == posted);
      v[RULE_CFGIO_ADDRLEN] = known && (op > 8'h01) && al;
      v[RULE_DW_ALIGN] = (mem_io && (addr[1:0] != 2'b00)) || (cfg && addr[1]);
      v[RULE_QW_ALIGN] = known && (sbe != 4'h0) && addr[2];
      return v;
   endfunction

   task automatic print_summary();
      $display("reports checked %0d, value errors %0d, protocol errors %0d",
               reports_seen, value_errors, protocol_errors);
   endtask

   // --------------------------------------------------
   // bus driver
   // --------------------------------------------------

   task automatic drive_transfer(input opcode_t op, input logic pm, input logic nm,
                                 input logic npw, input logic al, input be_t fbe,
                                 input be_t sbe, input addr_t addr, input bit keep);
      report_t r;
      @(posedge clk);
      mreg_irdy <= 1'b1;
      mreg_trdy <= 1'b1;
      mreg_pmsgip <= pm;
      mreg_nmsgip <= nm;
      mreg_npwrite <= npw;
      mreg_addrlen <= al;
      mreg_opcode <= op;
      mreg_fbe <= fbe;
      mreg_sbe <= sbe;
      mreg_addr <= addr;
      r.posted = pm && !nm;
      r.flits = model_flits(op, al, sbe);
      r.rules = model_rules(op, r.posted, npw, al, sbe, addr);
      if (keep)
         exp_q.push_back(r);
   endtask

   task automatic drive_idle();
      @(posedge clk);
      mreg_irdy <= 1'b0;
      mreg_trdy <= 1'b0;
      mreg_pmsgip <= 1'b0;
      mreg_nmsgip <= 1'b0;
   endtask

   // one transfer every 12 cycles so that nothing is dropped
   task automatic send_spaced(input opcode_t op, input logic pm, input logic nm,
                              input logic npw, input logic al, input be_t fbe,
                              input be_t sbe, input addr_t addr);
      drive_transfer(op, pm, nm, npw, al, fbe, sbe, addr, 1'b1);
      drive_idle();
      repeat (10) @(posedge clk);
   endtask

   task automatic wait_drain();
      @(posedge clk);
      while (exp_q.size() != 0 || rpt_req || rpt_ack)
         @(posedge clk);
      repeat (2) @(posedge clk);
   endtask

   // --------------------------------------------------
   // test sequences
   // --------------------------------------------------

   task automatic run_legal(input int n);
      logic [31:0] r;
      logic [31:0] a;
      opcode_t op;
      logic posted;
      cur_test = "legal_flits";
      for (int i = 0; i < n; i++) begin
         r = stim_rand();
         a = stim_rand();
         op = opcode_t'(r % 6);
         posted = (op == OP_MWR) && r[9];
         send_spaced(op, posted | r[10], !posted, !posted, (op <= OP_MWR) && r[8],
                     r[23:20], r[15:12] & {4{r[16]}}, {a[31:3], 3'b000});
      end
   endtask

   task automatic run_class(input int n);
      logic [31:0] r;
      logic [31:0] a;
      cur_test = "msg_class";
      for (int i = 0; i < n; i++) begin
         r = stim_rand();
         a = stim_rand();
         send_spaced(opcode_t'(r % 6), r[8], r[9] | !r[8], r[10], 1'b0,
                     r[23:20], r[15:12], {a[31:3], 3'b000});
      end
   endtask

   task automatic run_opcode(input int n);
      logic [31:0] r;
      logic [31:0] a;
      opcode_t op;
      cur_test = "opcode_addrlen";
      for (int i = 0; i < n; i++) begin
         r = stim_rand();
         a = stim_rand();
         op = r[8] ? opcode_t'(r % 6) : r[31:24];
         send_spaced(op, 1'b0, 1'b1, 1'b1, r[9], r[23:20], r[15:12], {a[31:3], 3'b000});
      end
   endtask

   task automatic run_align(input int n);
      logic [31:0] r;
      opcode_t op;
      cur_test = "alignment";
      for (int i = 0; i < n; i++) begin
         r = stim_rand();
         op = opcode_t'(r % 6);
         send_spaced(op, 1'b0, 1'b1, 1'b1, (op <= OP_MWR) && r[8], r[23:20],
                     r[15:12] & {4{r[16]}}, stim_rand());
      end
   endtask

   // k back-to-back transfers while ack is held back
   // only the first one is reported
   task automatic run_drop(input int k);
      logic [31:0] r;
      int base;
      int expected;
      cur_test = "drop_count";
      wait_drain();
      @(posedge clk);
      ack_hold <= 1'b1;
      base = drop_count;
      for (int i = 0; i < k; i++) begin
         r = stim_rand();
         // only the first transfer is non-posted
         drive_transfer(opcode_t'(r % 6), i != 0, i == 0, 1'b1, 1'b0, r[23:20], r[15:12],
                        {r[31:3], 3'b000}, i == 0);
      end
      drive_idle();
      repeat (k + 6) @(posedge clk);
      expected = (base + k - 1 > 255) ? 255 : base + k - 1;
      assert (drop_count == drop_cnt_t'(expected)) else begin
         $display("[ERROR] %s drop_count expected %0d actual %0d",
                  cur_test, expected, drop_count);
         value_errors++;
      end
      assert (rpt_req) else begin
         $display("no report was raised while the ack was held back");
         protocol_errors++;
      end
      ack_hold <= 1'b0;
      wait_drain();
   endtask

   // --------------------------------------------------
   // ack responder and report checks
   // --------------------------------------------------

   initial begin : ack_responder
      int unsigned delay;
      report_t e;
      rpt_ack = 1'b0;
      wait (reset === 1'b1);
      forever begin
         @(posedge clk);
         if (rpt_req && !rpt_ack && !ack_hold) begin
            reports_seen++;
            if (exp_q.size() == 0) begin
               $display("report raised with no transfer left to report");
               protocol_errors++;
            end else begin
               e = exp_q.pop_front();
               assert (rpt_rules == e.rules) else begin
                  $display("[ERROR] %s rpt_rules expected %b actual %b",
                           cur_test, e.rules, rpt_rules);
                  value_errors++;
               end
               assert (rpt_flits == e.flits) else begin
                  $display("[ERROR] %s rpt_flits expected %0d actual %0d",
                           cur_test, e.flits, rpt_flits);
                  value_errors++;
               end
               assert (rpt_posted == e.posted) else begin
                  $display("[ERROR] %s rpt_posted expected %0b actual %0b",
                           cur_test, e.posted, rpt_posted);
                  value_errors++;
               end
            end
            delay = ack_rand() % 4;
            repeat (delay) @(posedge clk);
            rpt_ack <= 1'b1;
         end else if (!rpt_req && rpt_ack) begin
            rpt_ack <= 1'b0;
         end
      end
   end

   // four-phase ordering as seen on the pins
   always @(posedge clk) begin
      if (reset) begin
         if (rpt_req && !prev_req) begin
            assert (!prev_ack) else begin
               $display("rpt_req rose while rpt_ack was still high");
               protocol_errors++;
            end
         end
         if (!rpt_req && prev_req) begin
            assert (prev_ack) else begin
               $display("rpt_req fell before rpt_ack was raised");
               protocol_errors++;
            end
         end
      end
      prev_req = rpt_req;
      prev_ack = rpt_ack;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("run did not finish within %0d cycles, %0d reports still expected",
                  TIMEOUT_CYCLES, exp_q.size());
         print_summary();
         $display("Verification failed");
         $finish;
      end
   end

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------

   initial begin : stimulus
      reset = 1'b0;
      mreg_irdy = 1'b0;
      mreg_trdy = 1'b0;
      mreg_pmsgip = 1'b0;
      mreg_nmsgip = 1'b0;
      mreg_npwrite = 1'b0;
      mreg_addrlen = 1'b0;
      mreg_opcode = '0;
      mreg_fbe = '0;
      mreg_sbe = '0;
      mreg_addr = '0;
      repeat (8) @(posedge clk);
      reset <= 1'b1;
      @(posedge clk);
      assert (rpt_req == 1'b0) else begin
         $display("[ERROR] %s rpt_req expected 0 actual %0b", cur_test, rpt_req);
         value_errors++;
      end
      assert (drop_count == '0) else begin
         $display("[ERROR] %s drop_count expected 0 actual %0d", cur_test, drop_count);
         value_errors++;
      end
      run_legal(N_LEGAL);
      run_class(N_CLASS);
      run_opcode(N_OPCODE);
      run_align(N_ALIGN);
      // spaced transfers never overlap a pending report
      wait_drain();
      assert (drop_count == '0) else begin
         $display("[ERROR] %s drop_count expected 0 actual %0d", cur_test, drop_count);
         value_errors++;
      end
      run_drop(K_DROP_A);
      run_drop(K_DROP_B);
      wait_drain();
      repeat (10) @(posedge clk);
      print_summary();
      if (value_errors == 0 && protocol_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* project.f */
+incdir+include
rtl/mreg_msg_pkg.sv
rtl/mreg_check_pkg.sv
rtl/mreg_rec_if.sv
rtl/mreg_res_if.sv
rtl/mreg_capture.sv
rtl/mreg_rule_eval.sv
rtl/mreg_check_ctrl.sv
rtl/mreg_checker_top.sv
testbench/tb_mreg_checker.sv

/* run_sim.sh */
#!/bin/sh
# build and run the message checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_mreg_checker

verilator --binary --timing --assert -Wno-fatal \
   -f project.f \
   --top-module "$TOP" \
   -Mdir "$BUILD_DIR" \
   -o "$TOP"
if [ $? -ne 0 ]; then
   echo "run_sim: verilator build failed"
   exit 1
fi

"$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "run_sim: simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Verification failed" "$LOG_FILE"; then
   echo "run_sim: failures found in $LOG_FILE"
   exit 1
fi

if ! grep -q "Verification passed" "$LOG_FILE"; then
   echo "run_sim: simulation ended without a verdict"
   exit 1
fi

exit 0
